// ==== common/evt_config.svh ====
`ifndef EVT_CONFIG_SVH
`define EVT_CONFIG_SVH

`define EVT_ADDR_W 5                            // store address bits
`define EVT_DEPTH  (1 << `EVT_ADDR_W)           // store entries

`define EVT_TS_W   32                           // timestamp bits
`define EVT_CH_W   16                           // hit channels and beat width

// one stored record is a timestamp followed by the hit vector
`define EVT_WORD_W (`EVT_TS_W + `EVT_CH_W)

`endif

// ==== common/evt_pkg.sv ====
`default_nettype none

`include "evt_config.svh"

package evt_pkg;

   // timestamp sits above the hits so it leaves the bus first
   typedef struct packed
   {
      logic [`EVT_TS_W-1:0] ts;                 // capture time
      logic [`EVT_CH_W-1:0] hits;               // channel hit vector
   } event_rec_t;

   // same 48 bits seen as a record or as bus beats
   typedef union packed
   {
      event_rec_t                    rec;       // written by the stamper
      logic [2:0][`EVT_CH_W-1:0]     beats;     // beat 2 is ts high
   } event_word_u;

   typedef struct packed
   {
      logic                  empty;
      logic                  full;
      logic [`EVT_ADDR_W:0]  count;             // 0 to depth inclusive
   } fifo_status_t;

endpackage

`default_nettype wire

// ==== design/hit_stamper.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "evt_config.svh"

module hit_stamper
(
   input  wire logic                 clk,
   input  wire logic                 rst,
   input  wire logic [`EVT_CH_W-1:0] hits,
   input  wire logic                 overflow,
   output logic                      wr_en,
   output evt_pkg::event_word_u      wr_word,
   output logic [15:0]               drop_count
);

   logic [`EVT_TS_W-1:0] ts_cnt;                // free running, wraps naturally

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ts_cnt <= '0;
      end
      else
      begin
         ts_cnt <= ts_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wr_en <= 1'b0;
      end
      else
      begin
         wr_en <= |hits;                        // one write per hit cycle
      end
   end

   // record carries the counter value seen at the sampling edge
   always_ff @(posedge clk)
   begin
      if (|hits)
      begin
         wr_word.rec.ts   <= ts_cnt;
         wr_word.rec.hits <= hits;
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         drop_count <= '0;
      end
      else if (overflow && (drop_count != '1))
      begin
         drop_count <= drop_count + 1'b1;       // sticks at all ones
      end
   end

endmodule

`default_nettype wire

// ==== event_fifo/event_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "evt_config.svh"

module event_fifo
(
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire logic                  wr_en,
   input  wire evt_pkg::event_word_u  wr_word,
   input  wire logic                  rd_en,
   output evt_pkg::event_word_u       rd_word,
   output logic                       rd_valid,
   output logic                       overflow,
   output evt_pkg::fifo_status_t      status
);

   logic [`EVT_WORD_W-1:0] mem [`EVT_DEPTH];
   logic [`EVT_ADDR_W-1:0] wr_ptr;
   logic [`EVT_ADDR_W-1:0] rd_ptr;
   logic [`EVT_ADDR_W:0]   count;               // one extra bit to hold a full store
   logic                   empty;
   logic                   full;
   logic                   wr_ok;
   logic                   rd_ok;

   assign empty = (count == '0);
   assign full  = (count == (`EVT_ADDR_W+1)'(`EVT_DEPTH));

   assign wr_ok = wr_en && !full;
   assign rd_ok = rd_en && !empty;

   assign overflow = wr_en && full;             // refused write, same cycle

   assign status.empty = empty;
   assign status.full  = full;
   assign status.count = count;

   always_ff @(posedge clk)
   begin
      if (wr_ok)
      begin
         mem[wr_ptr] <= wr_word;
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (wr_ok)
         begin
            wr_ptr <= wr_ptr + 1'b1;            // wraps at depth
         end
         if (rd_ok)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         count <= '0;
      end
      else
      begin
         case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;            // both or neither
         endcase
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rd_word  <= '0;
         rd_valid <= 1'b0;
      end
      else
      begin
         rd_valid <= rd_ok;                     // single cycle pulse
         if (rd_ok)
         begin
            rd_word <= mem[rd_ptr];
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/beat_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "evt_config.svh"

module beat_serializer
(
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire evt_pkg::event_word_u  rd_word,
   input  wire logic                  rd_valid,
   output logic                       rd_en,
   output logic [`EVT_CH_W-1:0]       beat_data,
   output logic                       beat_valid,
   output logic                       beat_first
);

   typedef enum logic [1:0]
   {
      S_IDLE  = 2'd0,
      S_BEAT2 = 2'd1,
      S_BEAT1 = 2'd2,
      S_BEAT0 = 2'd3
   } state_t;

   state_t               state;
   evt_pkg::event_word_u word_q;                // record being sent

   // asking again during the last beat lets the next word land in idle,
   // which keeps a full store draining at one record every four cycles
   assign rd_en = ((state == S_IDLE) && !rd_valid) || (state == S_BEAT0);

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= S_IDLE;
      end
      else
      begin
         case (state)
            S_IDLE:  state <= rd_valid ? S_BEAT2 : S_IDLE;
            S_BEAT2: state <= S_BEAT1;
            S_BEAT1: state <= S_BEAT0;
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (rd_valid)
      begin
         word_q <= rd_word;                     // only arrives while idle
      end
   end

   always_comb
   begin
      case (state)
         S_BEAT2: beat_data = word_q.beats[2];  // ts high half
         S_BEAT1: beat_data = word_q.beats[1];  // ts low half
         S_BEAT0: beat_data = word_q.beats[0];  // hits
         default: beat_data = '0;
      endcase
   end

   assign beat_valid = (state != S_IDLE);
   assign beat_first = (state == S_BEAT2);

endmodule

`default_nettype wire

// ==== design/event_capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "evt_config.svh"

module event_capture_top
(
   input  wire logic                 clk,
   input  wire logic                 rst,
   input  wire logic [`EVT_CH_W-1:0] hits,
   output logic [`EVT_CH_W-1:0]      beat_data,
   output logic                      beat_valid,
   output logic                      beat_first,
   output logic [15:0]               drop_count,
   output evt_pkg::fifo_status_t     status
);

   logic                 wr_en;
   evt_pkg::event_word_u wr_word;
   logic                 overflow;
   logic                 rd_en;
   evt_pkg::event_word_u rd_word;
   logic                 rd_valid;

   hit_stamper hit_stamper_inst
   (
      .clk        (clk),
      .rst        (rst),
      .hits       (hits),
      .overflow   (overflow),
      .wr_en      (wr_en),
      .wr_word    (wr_word),
      .drop_count (drop_count)
   );

   event_fifo event_fifo_inst
   (
      .clk      (clk),
      .rst      (rst),
      .wr_en    (wr_en),
      .wr_word  (wr_word),
      .rd_en    (rd_en),
      .rd_word  (rd_word),
      .rd_valid (rd_valid),
      .overflow (overflow),
      .status   (status)
   );

   beat_serializer beat_serializer_inst
   (
      .clk        (clk),
      .rst        (rst),
      .rd_word    (rd_word),
      .rd_valid   (rd_valid),
      .rd_en      (rd_en),
      .beat_data  (beat_data),
      .beat_valid (beat_valid),
      .beat_first (beat_first)
   );

endmodule

`default_nettype wire

// ==== bench/tb_event_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "evt_config.svh"

module tb_event_capture;

   localparam int CLK_PERIOD      = 100;
   localparam int SPARSE_CYCLES   = 400;
   localparam int BURST_CYCLES    = 200;
   localparam int IDLE_CYCLES     = 50;
   localparam int DRAIN_LIMIT     = 300;              // cycles allowed for the store to empty
   localparam int TOTAL_STIM      = SPARSE_CYCLES + BURST_CYCLES + IDLE_CYCLES + 20;
   localparam int WATCHDOG_CYCLES = TOTAL_STIM * 4 + 200;

   logic                   clk;
   logic                   rst;
   logic [`EVT_CH_W-1:0]   hits;
   logic [`EVT_CH_W-1:0]   beat_data;
   logic                   beat_valid;
   logic                   beat_first;
   logic [15:0]            drop_count;
   evt_pkg::fifo_status_t  status;

   int                     seed = 32'h213e_ed0d;
   logic [31:0]            rnd;
   logic [`EVT_WORD_W-1:0] model_q [$];               // generated records, oldest first
   logic [`EVT_WORD_W-1:0] got_word = '0;
   logic [`EVT_WORD_W-1:0] last_rec = '0;
   int                     cyc = 0;                   // cycles since reset release
   int                     beat_idx = 0;
   int                     beats_seen = 0;
   int                     generated = 0;
   int                     received = 0;
   int                     skipped = 0;
   int                     errors = 0;
   int                     checks = 0;
   logic                   full_seen = 1'b0;
   int                     single_ts;
   int                     mark;
   int                     beats_mark;

   event_capture_top event_capture_top_inst
   (
      .clk        (clk),
      .rst        (rst),
      .hits       (hits),
      .beat_data  (beat_data),
      .beat_valid (beat_valid),
      .beat_first (beat_first),
      .drop_count (drop_count),
      .status     (status)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // a record is the timestamp on top of the hit vector
   function automatic logic [`EVT_WORD_W-1:0] expected_record(input logic [`EVT_TS_W-1:0] ts,
                                                              input logic [`EVT_CH_W-1:0] h);
      return {ts, h};
   endfunction

   function automatic logic [`EVT_CH_W-1:0] make_nonzero(input logic [`EVT_CH_W-1:0] v);
      return (v == '0) ? `EVT_CH_W'(1) : v;
   endfunction

   task automatic check(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
      checks++;
      if (expected !== actual)
      begin
         errors++;
         $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
      end
   endtask

   task automatic drive_cycle(input logic [`EVT_CH_W-1:0] value);
      @(posedge clk);
      #1;
      hits = value;
   endtask

   // store empty and no beats for a stretch means nothing is left in flight
   task automatic wait_drain(input string name);
      int quiet;
      int waited;
      quiet  = 0;
      waited = 0;
      while ((quiet < 8) && (waited < DRAIN_LIMIT))
      begin
         @(negedge clk);
         waited++;
         if (status.empty && !beat_valid)
         begin
            quiet++;
         end
         else
         begin
            quiet = 0;
         end
      end
      if (quiet < 8)
      begin
         errors++;
         $display("ERROR: %s: store did not drain within %0d cycles", name, DRAIN_LIMIT);
      end
   endtask

   // anything ahead of the match in the model was dropped by the store
   task automatic match_record(input logic [`EVT_WORD_W-1:0] rec);
      int pos;
      int i;
      pos = -1;
      for (i = 0; i < model_q.size(); i++)
      begin
         if ((pos < 0) && (model_q[i] == rec))
         begin
            pos = i;
         end
      end
      if (pos < 0)
      begin
         errors++;
         $display("ERROR: received record 0x%012h matches no generated record", rec);
      end
      else
      begin
         skipped += pos;
         repeat (pos + 1) void'(model_q.pop_front());
         received++;
         last_rec = rec;
      end
   endtask

   // reference model samples hits here with the current cycle as ts
   always @(posedge clk)
   begin
      if (rst)
      begin
         cyc = 0;
      end
      else
      begin
         if (hits != '0)
         begin
            model_q.push_back(expected_record(cyc[`EVT_TS_W-1:0], hits));
            generated++;
         end
         cyc++;
      end
   end

   // collector joins beats into records and compares against the model
   always @(negedge clk)
   begin
      if (!rst)
      begin
         if (status.full)
         begin
            full_seen = 1'b1;
         end
         if (beat_valid)
         begin
            check("beat_first", 64'(beat_idx == 0), 64'(beat_first));
            got_word = {got_word[`EVT_WORD_W-`EVT_CH_W-1:0], beat_data};
            beat_idx++;
            beats_seen++;
            if (beat_idx == 3)
            begin
               match_record(got_word);
               beat_idx = 0;
            end
         end
      end
   end

   initial
   begin
      rst  = 1'b1;
      hits = '0;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;

      @(negedge clk);
      check("reset_empty", 64'(1), 64'(status.empty));
      check("reset_full", 64'(0), 64'(status.full));
      check("reset_count", 64'(0), 64'(status.count));
      check("reset_beat_valid", 64'(0), 64'(beat_valid));
      check("reset_drop_count", 64'(0), 64'(drop_count));

      mark       = received;
      beats_mark = beats_seen;
      drive_cycle(16'ha5c3);
      single_ts = cyc;                                // sampled on the next edge
      drive_cycle('0);
      wait_drain("single");
      check("single_records", 64'(mark + 1), 64'(received));
      check("single_beats", 64'(beats_mark + 3), 64'(beats_seen));
      check("single_record", 64'(expected_record(single_ts[`EVT_TS_W-1:0], 16'ha5c3)),
            64'(last_rec));

      repeat (SPARSE_CYCLES)
      begin
         rnd = $random(seed);
         if (rnd[2:0] == 3'd0)
         begin
            drive_cycle(make_nonzero(rnd[31:16]));
         end
         else
         begin
            drive_cycle('0);
         end
      end
      drive_cycle('0);
      wait_drain("sparse");
      check("sparse_skipped", 64'(0), 64'(skipped));
      check("sparse_leftover", 64'(0), 64'(model_q.size()));
      check("sparse_drop_count", 64'(0), 64'(drop_count));

      repeat (BURST_CYCLES)
      begin
         rnd = $random(seed);
         drive_cycle(make_nonzero(rnd[15:0]));
      end
      drive_cycle('0);
      wait_drain("burst");
      check("burst_full_seen", 64'(1), 64'(full_seen));
      model_q.delete();                               // tail records were dropped by the store
      check("burst_drop_count", 64'(generated - received), 64'(drop_count));

      mark = received;
      repeat (IDLE_CYCLES) drive_cycle('0);
      @(negedge clk);
      check("drain_empty", 64'(1), 64'(status.empty));
      check("drain_full", 64'(0), 64'(status.full));
      check("drain_count", 64'(0), 64'(status.count));
      check("idle_records", 64'(mark), 64'(received));

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("Finished with no errors");
      end
      else
      begin
         $display("Finished with errors");
      end
      $finish;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("ERROR: simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+common
common/evt_pkg.sv
design/hit_stamper.sv
event_fifo/event_fifo.sv
design/beat_serializer.sv
design/event_capture_top.sv
bench/tb_event_capture.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_event_capture
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
